// ==== matrix_row_slot.sv ====
`timescale 1ns/1ps

module matrix_row_slot #(
	parameter int unsigned ROW_IDX = 0
) (
	input  logic                        i_clk,
	input  logic                        i_rstn,
	input  sram0_reader_pkg::col_idx_t  i_col,
	row_load_if.sink                    load,
	output sram0_reader_pkg::elem_t     o_elem
);

	sram0_reader_pkg::sram_word_t row_q;
	logic                         hit;

	// A row load addressed to this slot. Vector loads belong to the readout.
	assign hit = load.load_valid && !load.load_vec &&
	             (load.load_row == sram0_reader_pkg::row_idx_t'(ROW_IDX));

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			row_q <= '0;
		end else if (load.clear) begin
			row_q <= '0;
		end else if (hit) begin
			row_q <= load.load_data;
		end
	end

	// Column 0 sits in the least significant element of the word.
	assign o_elem = row_q[i_col * sram0_reader_pkg::ELEM_W +: sram0_reader_pkg::ELEM_W];

endmodule

// ==== operand_readout.sv ====
`timescale 1ns/1ps

module operand_readout (
	input  logic                         i_clk,
	input  logic                         i_rstn,
	input  sram0_reader_pkg::row_idx_t   i_row,
	input  sram0_reader_pkg::elem_t      i_row_elems [sram0_reader_pkg::NUM_ROWS],
	row_load_if.sink                     load,
	output sram0_reader_pkg::sram_word_t o_in_vector,
	output sram0_reader_pkg::elem_t      o_mat_vector
);

	sram0_reader_pkg::sram_word_t in_vec_q;

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			in_vec_q <= '0;
		end else if (load.clear) begin
			in_vec_q <= '0;
		end else if (load.load_valid && load.load_vec) begin
			in_vec_q <= load.load_data;
		end
	end

	assign o_in_vector = in_vec_q;

	// Each slot has already picked its column; only the row is chosen here.
	assign o_mat_vector = i_row_elems[i_row];

endmodule

// ==== row_load_if.sv ====
`timescale 1ns/1ps

interface row_load_if;

	logic                           load_valid;
	logic                           load_vec;
	sram0_reader_pkg::row_idx_t     load_row;
	sram0_reader_pkg::sram_word_t   load_data;
	logic                           clear;

	modport seq (
		output load_valid,
		output load_vec,
		output load_row,
		output load_data,
		output clear
	);

	modport sink (
		input load_valid,
		input load_vec,
		input load_row,
		input load_data,
		input clear
	);

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_sram0_reader
if [ $? -ne 0 ]; then
	echo "Verilator build failed."
	exit 1
fi

./obj_dir/Vtb_sram0_reader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
	exit 0
else
	echo "Pass line not found in $LOG."
	exit 1
fi

// ==== sram0_reader.sv ====
`timescale 1ns/1ps

module sram0_reader #(
	parameter int unsigned BASE_ADDR = 15
) (
	input  logic                          i_clk,
	input  logic                          i_rstn,
	input  logic                          i_read_reset,
	input  logic                          i_read_start,
	input  sram0_reader_pkg::elem_count_t i_count,
	input  sram0_reader_pkg::sram_word_t  i_read_data,
	output sram0_reader_pkg::sram_addr_t  o_read_addr,
	output sram0_reader_pkg::sram_word_t  o_in_vector,
	output sram0_reader_pkg::elem_t       o_mat_vector,
	output logic                          o_done
);

	sram0_reader_pkg::row_idx_t count_row;
	sram0_reader_pkg::col_idx_t count_col;
	sram0_reader_pkg::elem_t    row_elems [sram0_reader_pkg::NUM_ROWS];

	row_load_if load_bus ();

	assign count_col = i_count[sram0_reader_pkg::COL_W-1:0];
	assign count_row = i_count[sram0_reader_pkg::COUNT_W-1:sram0_reader_pkg::COL_W];

	sram_read_sequencer #(
		.BASE_ADDR (BASE_ADDR)
	) u_sequencer (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_read_start (i_read_start),
		.i_read_reset (i_read_reset),
		.i_read_data  (i_read_data),
		.o_read_addr  (o_read_addr),
		.o_done       (o_done),
		.load         (load_bus)
	);

	for (genvar r = 0; r < sram0_reader_pkg::NUM_ROWS; r++) begin : g_row
		matrix_row_slot #(
			.ROW_IDX (r)
		) u_slot (
			.i_clk  (i_clk),
			.i_rstn (i_rstn),
			.i_col  (count_col),
			.load   (load_bus),
			.o_elem (row_elems[r])
		);
	end

	operand_readout u_readout (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_row        (count_row),
		.i_row_elems  (row_elems),
		.load         (load_bus),
		.o_in_vector  (o_in_vector),
		.o_mat_vector (o_mat_vector)
	);

endmodule

// ==== sram0_reader_asserts.sv ====
`timescale 1ns/1ps

module sram0_reader_asserts #(
	parameter int unsigned BASE_ADDR = 15
) (
	input logic                         i_clk,
	input logic                         i_rstn,
	input logic                         i_read_reset,
	input sram0_reader_pkg::sram_addr_t i_read_addr,
	input logic                         i_done
);

	localparam sram0_reader_pkg::sram_addr_t ADDR_LO =
		sram0_reader_pkg::sram_addr_t'(BASE_ADDR);
	localparam sram0_reader_pkg::sram_addr_t ADDR_HI =
		sram0_reader_pkg::sram_addr_t'(BASE_ADDR + sram0_reader_pkg::NUM_ROWS);

	// Addresses never leave the vector word and the rows that follow it.
	a_addr_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
		(i_read_addr >= ADDR_LO) && (i_read_addr <= ADDR_HI))
		else $error("Read address %0d is outside the operand window.", i_read_addr);

	a_done_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_done && !i_read_reset |=> i_done)
		else $error("Done dropped without a read reset.");

	a_done_after_reset: assert property (@(posedge i_clk)
		$rose(i_rstn) |-> !i_done)
		else $error("Done is high right after reset release.");

endmodule

bind sram0_reader sram0_reader_asserts #(
	.BASE_ADDR (BASE_ADDR)
) u_asserts (
	.i_clk        (i_clk),
	.i_rstn       (i_rstn),
	.i_read_reset (i_read_reset),
	.i_read_addr  (o_read_addr),
	.i_done       (o_done)
);

// ==== sram0_reader_pkg.sv ====
package sram0_reader_pkg;

	// Buffer geometry of the operand loader.
	localparam int unsigned NUM_ROWS = 16;
	localparam int unsigned ELEM_W   = 16;
	localparam int unsigned NUM_COLS = 16;
	localparam int unsigned WORD_W   = NUM_COLS * ELEM_W;
	localparam int unsigned ADDR_W   = 5;

	// The flat element count splits into a row part above a column part.
	localparam int unsigned ROW_W   = $clog2(NUM_ROWS);
	localparam int unsigned COL_W   = $clog2(NUM_COLS);
	localparam int unsigned COUNT_W = ROW_W + COL_W;

	typedef logic [WORD_W-1:0]  sram_word_t;
	typedef logic [ADDR_W-1:0]  sram_addr_t;
	typedef logic [ELEM_W-1:0]  elem_t;
	typedef logic [COUNT_W-1:0] elem_count_t;
	typedef logic [ROW_W-1:0]   row_idx_t;
	typedef logic [COL_W-1:0]   col_idx_t;

	// READ_VEC fetches the input vector, READ_ROWS walks the matrix rows,
	// DRAIN waits for the last word to come back from the SRAM.
	typedef enum logic [2:0] {
		IDLE,
		READ_VEC,
		READ_ROWS,
		DRAIN,
		DONE
	} seq_state_t;

endpackage

// ==== sram_read_sequencer.sv ====
`timescale 1ns/1ps

module sram_read_sequencer #(
	parameter int unsigned BASE_ADDR = 15
) (
	input  logic                         i_clk,
	input  logic                         i_rstn,
	input  logic                         i_read_start,
	input  logic                         i_read_reset,
	input  sram0_reader_pkg::sram_word_t i_read_data,
	output sram0_reader_pkg::sram_addr_t o_read_addr,
	output logic                         o_done,
	row_load_if.seq                      load
);

	sram0_reader_pkg::seq_state_t state;
	sram0_reader_pkg::seq_state_t next_state;
	sram0_reader_pkg::row_idx_t   row_cnt;
	sram0_reader_pkg::row_idx_t   tgt_row_q;
	logic                         last_row;
	logic                         tgt_valid;
	logic                         tgt_vec;
	logic                         tgt_valid_q;
	logic                         tgt_vec_q;

	assign last_row = (row_cnt == sram0_reader_pkg::row_idx_t'(sram0_reader_pkg::NUM_ROWS - 1));

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state <= sram0_reader_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			sram0_reader_pkg::IDLE: begin
				if (i_read_start) begin
					next_state = sram0_reader_pkg::READ_VEC;
				end
			end
			sram0_reader_pkg::READ_VEC: begin
				next_state = sram0_reader_pkg::READ_ROWS;
			end
			sram0_reader_pkg::READ_ROWS: begin
				if (last_row) begin
					next_state = sram0_reader_pkg::DRAIN;
				end
			end
			sram0_reader_pkg::DRAIN: begin
				next_state = sram0_reader_pkg::DONE;
			end
			sram0_reader_pkg::DONE: begin
				if (i_read_reset) begin
					next_state = sram0_reader_pkg::IDLE;
				end
			end
			default: begin
				next_state = sram0_reader_pkg::IDLE;
			end
		endcase
	end

	// The row counter only advances while rows are being addressed.
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			row_cnt <= '0;
		end else if (state == sram0_reader_pkg::READ_ROWS) begin
			row_cnt <= row_cnt + 1'b1;
		end else begin
			row_cnt <= '0;
		end
	end

	always_comb begin
		o_read_addr = sram0_reader_pkg::sram_addr_t'(BASE_ADDR);
		if (state == sram0_reader_pkg::READ_ROWS) begin
			o_read_addr = sram0_reader_pkg::sram_addr_t'(BASE_ADDR + 1 + row_cnt);
		end
	end

	assign tgt_valid = (state == sram0_reader_pkg::READ_VEC) ||
	                   (state == sram0_reader_pkg::READ_ROWS);
	assign tgt_vec   = (state == sram0_reader_pkg::READ_VEC);

	// The SRAM answers one cycle late, so the target of this cycle's address
	// is held for one cycle and travels next to the returned word.
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			tgt_valid_q <= 1'b0;
			tgt_vec_q   <= 1'b0;
			tgt_row_q   <= '0;
		end else begin
			tgt_valid_q <= tgt_valid;
			tgt_vec_q   <= tgt_vec;
			tgt_row_q   <= row_cnt;
		end
	end

	assign load.load_valid = tgt_valid_q;
	assign load.load_vec   = tgt_vec_q;
	assign load.load_row   = tgt_row_q;
	assign load.load_data  = i_read_data;
	assign load.clear      = (state == sram0_reader_pkg::IDLE);

	assign o_done = (state == sram0_reader_pkg::DONE);

endmodule

// ==== tb_sram0_reader.sv ====
`timescale 1ns/1ps

module tb_sram0_reader;

	localparam int unsigned BASE_ADDR  = 15;
	localparam int unsigned MEM_DEPTH  = 32;
	localparam int          DONE_EDGE  = 19;
	localparam int          WAIT_LIMIT = 100;
	localparam int          NUM_COUNTS = 1 << sram0_reader_pkg::COUNT_W;
	localparam int          CHK_OFF    = 0;
	localparam int          CHK_ZERO   = 1;
	localparam int          CHK_REF    = 2;

	logic                          i_clk;
	logic                          i_rstn;
	logic                          i_read_reset;
	logic                          i_read_start;
	sram0_reader_pkg::elem_count_t i_count;
	sram0_reader_pkg::sram_word_t  i_read_data;
	sram0_reader_pkg::sram_addr_t  o_read_addr;
	sram0_reader_pkg::sram_word_t  o_in_vector;
	sram0_reader_pkg::elem_t       o_mat_vector;
	logic                          o_done;

	sram0_reader_pkg::sram_word_t  mem [MEM_DEPTH];
	int                            chk_mode;

	sram0_reader #(
		.BASE_ADDR (BASE_ADDR)
	) dut_i (
		.i_clk        (i_clk),
		.i_rstn       (i_rstn),
		.i_read_reset (i_read_reset),
		.i_read_start (i_read_start),
		.i_count      (i_count),
		.i_read_data  (i_read_data),
		.o_read_addr  (o_read_addr),
		.o_in_vector  (o_in_vector),
		.o_mat_vector (o_mat_vector),
		.o_done       (o_done)
	);

	always #20 i_clk = ~i_clk;

	// SRAM model with one cycle of read latency.
	always @(posedge i_clk) begin
		i_read_data <= mem[o_read_addr];
	end

	task automatic fail_stop();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_word(input string name, input sram0_reader_pkg::sram_word_t got,
	                          input sram0_reader_pkg::sram_word_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_elem(input string name, input sram0_reader_pkg::elem_t got,
	                          input sram0_reader_pkg::elem_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h count=%h", $time, name, got, exp, i_count);
			fail_stop();
		end
	endtask

	task automatic check_addr(input string name, input sram0_reader_pkg::sram_addr_t got,
	                          input sram0_reader_pkg::sram_addr_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			fail_stop();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
			fail_stop();
		end
	endtask

	// Column c of a row word is element c counted from the least significant end.
	function automatic sram0_reader_pkg::elem_t ref_elem(input sram0_reader_pkg::elem_count_t cnt);
		sram0_reader_pkg::sram_word_t row_word;
		int                           row;
		int                           col;
		row      = int'(cnt[sram0_reader_pkg::COUNT_W-1:sram0_reader_pkg::COL_W]);
		col      = int'(cnt[sram0_reader_pkg::COL_W-1:0]);
		row_word = mem[BASE_ADDR + 1 + row];
		return row_word[col * sram0_reader_pkg::ELEM_W +: sram0_reader_pkg::ELEM_W];
	endfunction

	// Address expected in the cycle after edge cyc, with the start drive at edge 0.
	function automatic sram0_reader_pkg::sram_addr_t exp_addr(input int cyc);
		if (cyc >= 2 && cyc <= sram0_reader_pkg::NUM_ROWS + 1) begin
			return sram0_reader_pkg::sram_addr_t'(BASE_ADDR + cyc - 1);
		end
		return sram0_reader_pkg::sram_addr_t'(BASE_ADDR);
	endfunction

	always @(negedge i_clk) begin
		if (chk_mode == CHK_ZERO) begin
			check_word("o_in_vector", o_in_vector, '0);
			check_elem("o_mat_vector", o_mat_vector, '0);
		end else if (chk_mode == CHK_REF) begin
			check_word("o_in_vector", o_in_vector, mem[BASE_ADDR]);
			check_elem("o_mat_vector", o_mat_vector, ref_elem(i_count));
		end
	end

	task automatic fill_mem();
		for (int a = 0; a < MEM_DEPTH; a++) begin
			for (int j = 0; j < sram0_reader_pkg::WORD_W / 32; j++) begin
				mem[a][j*32 +: 32] = $urandom();
			end
		end
	endtask

	task automatic sweep_counts(input int mode);
		for (int i = 0; i < NUM_COUNTS; i++) begin
			@(posedge i_clk);
			i_count <= sram0_reader_pkg::elem_count_t'(i);
			chk_mode = mode;
		end
		@(posedge i_clk);
		chk_mode = CHK_OFF;
	endtask

	task automatic run_read(input bit noisy);
		int cyc;
		bit seen_done;
		cyc       = 0;
		seen_done = 1'b0;
		@(posedge i_clk);
		i_read_start <= 1'b1;
		while (!seen_done) begin
			@(posedge i_clk);
			cyc++;
			// Extra start pulses land while the read is busy and must be ignored.
			i_read_start <= noisy && (cyc % 4 == 1);
			@(negedge i_clk);
			check_addr("o_read_addr", o_read_addr, exp_addr(cyc));
			check_bit("o_done", o_done, cyc == DONE_EDGE);
			seen_done = o_done;
			if (!seen_done && cyc >= WAIT_LIMIT) begin
				$display("Timeout: o_done never rose after the start pulse.");
				fail_stop();
			end
		end
	endtask

	task automatic hold_in_done();
		for (int i = 0; i < 4; i++) begin
			@(posedge i_clk);
			i_read_start <= (i % 2 == 0);
			@(negedge i_clk);
			check_bit("o_done", o_done, 1'b1);
			check_addr("o_read_addr", o_read_addr, sram0_reader_pkg::sram_addr_t'(BASE_ADDR));
		end
		@(posedge i_clk);
		i_read_start <= 1'b0;
	endtask

	task automatic release_read();
		int cyc;
		cyc = 0;
		@(posedge i_clk);
		i_read_reset <= 1'b1;
		do begin
			@(posedge i_clk);
			i_read_reset <= 1'b0;
			cyc++;
			@(negedge i_clk);
			if (o_done && cyc >= WAIT_LIMIT) begin
				$display("Timeout: o_done stayed high after the read reset.");
				fail_stop();
			end
		end while (o_done);
		if (cyc != 1) begin
			$display("ERR t=%0t o_done fall delay got=%0d exp=1", $time, cyc);
			fail_stop();
		end
		@(negedge i_clk);
		check_word("o_in_vector", o_in_vector, '0);
		check_elem("o_mat_vector", o_mat_vector, '0);
		check_addr("o_read_addr", o_read_addr, sram0_reader_pkg::sram_addr_t'(BASE_ADDR));
	endtask

	initial begin
		i_clk        = 1'b0;
		i_rstn       = 1'b0;
		i_read_reset = 1'b0;
		i_read_start = 1'b0;
		i_count      = '0;
		i_read_data  = '0;
		chk_mode     = CHK_OFF;
		void'($urandom(32'heef75937));
		fill_mem();
		repeat (2) @(posedge i_clk);
		i_rstn <= 1'b1;
		@(negedge i_clk);
		check_bit("o_done", o_done, 1'b0);
		check_addr("o_read_addr", o_read_addr, sram0_reader_pkg::sram_addr_t'(BASE_ADDR));
		sweep_counts(CHK_ZERO);

		run_read(1'b0);
		sweep_counts(CHK_REF);
		hold_in_done();
		sweep_counts(CHK_REF);
		release_read();
		sweep_counts(CHK_ZERO);

		// Second read over fresh contents, with stray start pulses.
		fill_mem();
		run_read(1'b1);
		sweep_counts(CHK_REF);
		release_read();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
sram0_reader_pkg.sv
row_load_if.sv
sram_read_sequencer.sv
matrix_row_slot.sv
operand_readout.sv
sram0_reader.sv
sram0_reader_asserts.sv
tb_sram0_reader.sv
